// File: pip_pkg.sv
`default_nettype none

package pip_pkg;

  // Datapath and register file sizes
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 16;
  localparam int REG_W    = 4;
  localparam int IMM_W    = 16;

  // Queue and reorder buffer sizes
  localparam int IQ_DEPTH  = 8;
  localparam int IQ_IDX_W  = 3;
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = 3;

  localparam int MUL_STAGES = 3;

  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_MUL
  } op_e;

  // Decoded instruction as it arrives on the credit port
  typedef struct packed {
    op_e              op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [IMM_W-1:0] imm;
  } inst_t;

  typedef struct packed {
    logic                 valid;
    op_e                  op;
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
    logic [ROB_IDX_W-1:0] idx;
  } exec_req_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_IDX_W-1:0] idx;
    logic [XLEN-1:0]      value;
  } wb_t;

  // hit: producer in flight, ready: its value is done
  typedef struct packed {
    logic            hit;
    logic            ready;
    logic [XLEN-1:0] value;
  } src_lookup_t;

  typedef struct packed {
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  value;
  } retire_t;

endpackage

`default_nettype wire

// File: inst_queue.sv
`default_nettype none

module inst_queue (
  input  logic           clock,
  input  logic           rst_n,
  input  logic           push,
  input  pip_pkg::inst_t push_inst,
  input  logic           pop,
  output pip_pkg::inst_t head_inst,
  output logic           head_valid
);

  pip_pkg::inst_t                 mem [pip_pkg::IQ_DEPTH];
  logic [pip_pkg::IQ_IDX_W-1:0]   rd_ptr;
  logic [pip_pkg::IQ_IDX_W-1:0]   wr_ptr;
  logic [pip_pkg::IQ_IDX_W:0]     count;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Credits keep push from ever hitting a full queue
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= push_inst;
    end
  end

  assign head_inst  = mem[rd_ptr];
  assign head_valid = (count != '0);

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`default_nettype none

module issue_ctrl (
  input  logic                              clock,
  input  logic                              rst_n,
  input  pip_pkg::inst_t                    head_inst,
  input  logic                              head_valid,
  output logic                              pop,
  input  pip_pkg::src_lookup_t              lookup_a,
  input  pip_pkg::src_lookup_t              lookup_b,
  input  logic [pip_pkg::XLEN-1:0]          rf_a,
  input  logic [pip_pkg::XLEN-1:0]          rf_b,
  input  logic                              rob_full,
  input  logic [pip_pkg::ROB_IDX_W-1:0]     rob_tail,
  output logic                              alloc,
  output logic [pip_pkg::REG_W-1:0]         alloc_rd,
  output pip_pkg::exec_req_t                alu_req,
  output pip_pkg::exec_req_t                mul_req
);

  logic               a_ok;
  logic               b_ok;
  logic               issue;
  logic               is_mul;
  pip_pkg::exec_req_t req_d;

  // A source is usable unless its producer is still computing
  assign a_ok   = !lookup_a.hit || lookup_a.ready;
  assign b_ok   = !lookup_b.hit || lookup_b.ready;
  assign issue  = head_valid && !rob_full && a_ok && b_ok;
  assign is_mul = (head_inst.op == pip_pkg::OP_MUL);

  assign pop      = issue;
  assign alloc    = issue;
  assign alloc_rd = head_inst.rd;

  always_comb begin
    req_d       = '0;
    req_d.op    = head_inst.op;
    req_d.idx   = rob_tail;
    if (head_inst.op == pip_pkg::OP_LI) begin
      req_d.a = {{(pip_pkg::XLEN - pip_pkg::IMM_W){1'b0}}, head_inst.imm};
    end else if (lookup_a.hit) begin
      req_d.a = lookup_a.value;
    end else begin
      req_d.a = rf_a;
    end
    if (lookup_b.hit) begin
      req_d.b = lookup_b.value;
    end else begin
      req_d.b = rf_b;
    end
  end

  // Both units see the same payload, only one valid is raised
  always_ff @(posedge clock) begin
    alu_req <= req_d;
    mul_req <= req_d;
    if (!rst_n) begin
      alu_req.valid <= 1'b0;
      mul_req.valid <= 1'b0;
    end else begin
      alu_req.valid <= issue && !is_mul;
      mul_req.valid <= issue && is_mul;
    end
  end

endmodule

`default_nettype wire

// File: rob.sv
`default_nettype none

module rob (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              alloc,
  input  logic [pip_pkg::REG_W-1:0]         alloc_rd,
  output logic                              full,
  output logic [pip_pkg::ROB_IDX_W-1:0]     tail,
  input  logic [pip_pkg::REG_W-1:0]         query_a,
  input  logic [pip_pkg::REG_W-1:0]         query_b,
  output pip_pkg::src_lookup_t              lookup_a,
  output pip_pkg::src_lookup_t              lookup_b,
  input  pip_pkg::wb_t                      alu_wb,
  input  pip_pkg::wb_t                      mul_wb,
  output logic                              retire_valid,
  output pip_pkg::retire_t                  retire
);

  logic [pip_pkg::REG_W-1:0]      rd_q    [pip_pkg::ROB_DEPTH];
  logic [pip_pkg::XLEN-1:0]       value_q [pip_pkg::ROB_DEPTH];
  logic                           done_q  [pip_pkg::ROB_DEPTH];
  logic [pip_pkg::ROB_IDX_W-1:0]  head;
  logic [pip_pkg::ROB_IDX_W:0]    count;

  // Walk from oldest to youngest so the last match wins
  function automatic pip_pkg::src_lookup_t find_src(
    input logic [pip_pkg::REG_W-1:0] reg_addr
  );
    pip_pkg::src_lookup_t          res;
    logic [pip_pkg::ROB_IDX_W-1:0] slot;
    res = '0;
    for (int i = 0; i < pip_pkg::ROB_DEPTH; i++) begin
      slot = head + i[pip_pkg::ROB_IDX_W-1:0];
      if (i < int'(count) && rd_q[slot] == reg_addr) begin
        res.hit   = 1'b1;
        res.ready = done_q[slot];
        res.value = value_q[slot];
      end
    end
    return res;
  endfunction

  always_comb begin
    lookup_a = find_src(query_a);
    lookup_b = find_src(query_b);
  end

  assign full         = (count == pip_pkg::ROB_DEPTH);
  assign retire_valid = (count != '0) && done_q[head];
  assign retire.rd    = rd_q[head];
  assign retire.value = value_q[head];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < pip_pkg::ROB_DEPTH; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (alloc) begin
        done_q[tail] <= 1'b0;
        tail         <= tail + 1'b1;
      end
      if (alu_wb.valid) begin
        done_q[alu_wb.idx] <= 1'b1;
      end
      if (mul_wb.valid) begin
        done_q[mul_wb.idx] <= 1'b1;
      end
      if (retire_valid) begin
        head <= head + 1'b1;
      end
      case ({alloc, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      rd_q[tail] <= alloc_rd;
    end
    if (alu_wb.valid) begin
      value_q[alu_wb.idx] <= alu_wb.value;
    end
    if (mul_wb.valid) begin
      value_q[mul_wb.idx] <= mul_wb.value;
    end
  end

endmodule

`default_nettype wire

// File: alu_unit.sv
`default_nettype none

module alu_unit (
  input  logic               clock,
  input  logic               rst_n,
  input  pip_pkg::exec_req_t req,
  output pip_pkg::wb_t       wb
);

  logic [pip_pkg::XLEN-1:0] result;

  always_comb begin
    case (req.op)
      pip_pkg::OP_ADD: result = req.a + req.b;
      pip_pkg::OP_SUB: result = req.a - req.b;
      pip_pkg::OP_AND: result = req.a & req.b;
      pip_pkg::OP_OR:  result = req.a | req.b;
      pip_pkg::OP_XOR: result = req.a ^ req.b;
      pip_pkg::OP_SLL: result = req.a << req.b[4:0];
      // OP_LI passes the immediate through
      default:         result = req.a;
    endcase
  end

  always_ff @(posedge clock) begin
    wb.idx   <= req.idx;
    wb.value <= result;
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= req.valid;
    end
  end

endmodule

`default_nettype wire

// File: mul_unit.sv
`default_nettype none

module mul_unit (
  input  logic               clock,
  input  logic               rst_n,
  input  pip_pkg::exec_req_t req,
  output pip_pkg::wb_t       wb
);

  logic                           valid_q [pip_pkg::MUL_STAGES];
  logic [pip_pkg::ROB_IDX_W-1:0]  idx_q   [pip_pkg::MUL_STAGES];
  logic [pip_pkg::XLEN-1:0]       pp_lo_q;
  logic [pip_pkg::XLEN/2-1:0]     pp_mid_q;
  logic [pip_pkg::XLEN-1:0]       prod_q  [1:pip_pkg::MUL_STAGES-1];

  always_ff @(posedge clock) begin
    // First stage splits into half-width partial products
    pp_lo_q  <= req.a[pip_pkg::XLEN/2-1:0] * req.b[pip_pkg::XLEN/2-1:0];
    // Only the low half of the cross terms reaches the result
    pp_mid_q <= req.a[pip_pkg::XLEN-1:pip_pkg::XLEN/2] * req.b[pip_pkg::XLEN/2-1:0]
              + req.a[pip_pkg::XLEN/2-1:0] * req.b[pip_pkg::XLEN-1:pip_pkg::XLEN/2];
    prod_q[1] <= pp_lo_q + {pp_mid_q, {(pip_pkg::XLEN/2){1'b0}}};
    for (int i = 2; i < pip_pkg::MUL_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
    idx_q[0] <= req.idx;
    for (int i = 1; i < pip_pkg::MUL_STAGES; i++) begin
      idx_q[i] <= idx_q[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < pip_pkg::MUL_STAGES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= req.valid;
      for (int i = 1; i < pip_pkg::MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign wb.valid = valid_q[pip_pkg::MUL_STAGES-1];
  assign wb.idx   = idx_q[pip_pkg::MUL_STAGES-1];
  assign wb.value = prod_q[pip_pkg::MUL_STAGES-1];

endmodule

`default_nettype wire

// File: rfile.sv
`default_nettype none

module rfile (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [pip_pkg::REG_W-1:0]   rd_addr_a,
  input  logic [pip_pkg::REG_W-1:0]   rd_addr_b,
  output logic [pip_pkg::XLEN-1:0]    rd_data_a,
  output logic [pip_pkg::XLEN-1:0]    rd_data_b,
  input  logic                        wr_en,
  input  pip_pkg::retire_t            wr
);

  logic [pip_pkg::XLEN-1:0] regs [pip_pkg::NUM_REGS];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < pip_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.rd] <= wr.value;
    end
  end

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: pipeline.sv
`default_nettype none

module pipeline (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             inst_valid,
  input  pip_pkg::inst_t   inst,
  output logic             credit_return,
  output logic             retire_valid,
  output pip_pkg::retire_t retire
);

  pip_pkg::inst_t                 head_inst;
  logic                           head_valid;
  pip_pkg::src_lookup_t           lookup_a;
  pip_pkg::src_lookup_t           lookup_b;
  logic [pip_pkg::XLEN-1:0]       rf_a;
  logic [pip_pkg::XLEN-1:0]       rf_b;
  logic                           rob_full;
  logic [pip_pkg::ROB_IDX_W-1:0]  rob_tail;
  logic                           alloc;
  logic [pip_pkg::REG_W-1:0]      alloc_rd;
  pip_pkg::exec_req_t             alu_req;
  pip_pkg::exec_req_t             mul_req;
  pip_pkg::wb_t                   alu_wb;
  pip_pkg::wb_t                   mul_wb;

  // Each pop frees one queue entry and returns its credit
  inst_queue inst_queue_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .push       (inst_valid),
    .push_inst  (inst),
    .pop        (credit_return),
    .head_inst  (head_inst),
    .head_valid (head_valid)
  );

  issue_ctrl issue_ctrl_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .head_inst  (head_inst),
    .head_valid (head_valid),
    .pop        (credit_return),
    .lookup_a   (lookup_a),
    .lookup_b   (lookup_b),
    .rf_a       (rf_a),
    .rf_b       (rf_b),
    .rob_full   (rob_full),
    .rob_tail   (rob_tail),
    .alloc      (alloc),
    .alloc_rd   (alloc_rd),
    .alu_req    (alu_req),
    .mul_req    (mul_req)
  );

  rob rob_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .alloc        (alloc),
    .alloc_rd     (alloc_rd),
    .full         (rob_full),
    .tail         (rob_tail),
    .query_a      (head_inst.rs1),
    .query_b      (head_inst.rs2),
    .lookup_a     (lookup_a),
    .lookup_b     (lookup_b),
    .alu_wb       (alu_wb),
    .mul_wb       (mul_wb),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  alu_unit alu_unit_inst (
    .clock (clock),
    .rst_n (rst_n),
    .req   (alu_req),
    .wb    (alu_wb)
  );

  mul_unit mul_unit_inst (
    .clock (clock),
    .rst_n (rst_n),
    .req   (mul_req),
    .wb    (mul_wb)
  );

  // Retired results land here at the same edge they leave the ROB
  rfile rfile_inst (
    .clock     (clock),
    .rst_n     (rst_n),
    .rd_addr_a (head_inst.rs1),
    .rd_addr_b (head_inst.rs2),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b),
    .wr_en     (retire_valid),
    .wr        (retire)
  );

endmodule

`default_nettype wire

// File: tb_pipeline.sv
`default_nettype none

module tb_pipeline;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  RESET_CYCLES    = 16;
  localparam int  CYCLES_PER_INST = 200;
  localparam int  RANDOM_INSTS    = 40;
  localparam time DRIVE_DELAY     = 2ns;

  logic             clock;
  logic             rst_n;
  logic             inst_valid;
  pip_pkg::inst_t   inst;
  logic             credit_return;
  logic             retire_valid;
  pip_pkg::retire_t retire;

  // Reference model state, updated in program order at send time
  logic [pip_pkg::XLEN-1:0] model_regs [pip_pkg::NUM_REGS];
  pip_pkg::retire_t         expected_q [$];
  int                       sent_total       = 0;
  int                       credits_back     = 0;
  int                       retired_total    = 0;
  int                       peak_outstanding = 0;
  int                       cycle_count      = 0;

  pipeline pipeline_inst (
    .clock         (clock),
    .rst_n         (rst_n),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .credit_return (credit_return),
    .retire_valid  (retire_valid),
    .retire        (retire)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_retire(input string name, input pip_pkg::retire_t got,
                              input pip_pkg::retire_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got rd=%h value=%h, expected rd=%h value=%h",
                          name, got.rd, got.value, exp.rd, exp.value));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic verify_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [pip_pkg::XLEN-1:0] model_value(input pip_pkg::inst_t ins);
    logic [pip_pkg::XLEN-1:0]   a;
    logic [pip_pkg::XLEN-1:0]   b;
    logic [2*pip_pkg::XLEN-1:0] wide;
    a    = model_regs[ins.rs1];
    b    = model_regs[ins.rs2];
    wide = {{pip_pkg::XLEN{1'b0}}, a} * {{pip_pkg::XLEN{1'b0}}, b};
    case (ins.op)
      pip_pkg::OP_LI:  return {{(pip_pkg::XLEN - pip_pkg::IMM_W){1'b0}}, ins.imm};
      pip_pkg::OP_ADD: return a + b;
      pip_pkg::OP_SUB: return a - b;
      pip_pkg::OP_AND: return a & b;
      pip_pkg::OP_OR:  return a | b;
      pip_pkg::OP_XOR: return a ^ b;
      pip_pkg::OP_SLL: return a << b[4:0];
      default:         return wide[pip_pkg::XLEN-1:0];
    endcase
  endfunction

  // Called 2 ns after a rising edge and returns at the same point
  task automatic send_inst(input pip_pkg::op_e op, input int rd, input int rs1,
                           input int rs2, input int imm);
    pip_pkg::inst_t   ins;
    pip_pkg::retire_t exp;
    ins.op  = op;
    ins.rd  = rd[pip_pkg::REG_W-1:0];
    ins.rs1 = rs1[pip_pkg::REG_W-1:0];
    ins.rs2 = rs2[pip_pkg::REG_W-1:0];
    ins.imm = imm[pip_pkg::IMM_W-1:0];
    // Hold off until a credit is available
    while (sent_total - credits_back >= pip_pkg::IQ_DEPTH) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
    exp.rd    = ins.rd;
    exp.value = model_value(ins);
    model_regs[ins.rd] = exp.value;
    expected_q.push_back(exp);
    inst_valid = 1'b1;
    inst       = ins;
    sent_total++;
    if (sent_total - credits_back > peak_outstanding) begin
      peak_outstanding = sent_total - credits_back;
    end
    @(posedge clock);
    #DRIVE_DELAY;
    inst_valid = 1'b0;
  endtask

  task automatic drain_pipeline();
    while (expected_q.size() != 0) begin
      @(negedge clock);
    end
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clock);
      if (i > 0) begin
        verify_flag("retire_valid", retire_valid, 1'b0);
        verify_flag("credit_return", credit_return, 1'b0);
      end
    end
    #DRIVE_DELAY;
    rst_n = 1'b1;
  endtask

  task automatic idle_after_reset();
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      verify_flag("retire_valid", retire_valid, 1'b0);
      verify_flag("credit_return", credit_return, 1'b0);
    end
    #DRIVE_DELAY;
    send_inst(pip_pkg::OP_ADD, 1, 0, 0, 0);
    drain_pipeline();
  endtask

  task automatic alu_chain();
    send_inst(pip_pkg::OP_LI, 2, 0, 0, 16'h1234);
    send_inst(pip_pkg::OP_ADD, 3, 2, 2, 0);
    send_inst(pip_pkg::OP_SUB, 4, 3, 2, 0);
    send_inst(pip_pkg::OP_AND, 5, 4, 3, 0);
    send_inst(pip_pkg::OP_OR, 6, 5, 2, 0);
    send_inst(pip_pkg::OP_XOR, 7, 6, 3, 0);
    send_inst(pip_pkg::OP_SLL, 8, 7, 2, 0);
    drain_pipeline();
  endtask

  // ALU results finish ahead of the multiply but must retire behind it
  task automatic mul_then_alu();
    send_inst(pip_pkg::OP_LI, 1, 0, 0, 16'h0123);
    send_inst(pip_pkg::OP_LI, 2, 0, 0, 16'h4567);
    drain_pipeline();
    send_inst(pip_pkg::OP_MUL, 3, 1, 2, 0);
    send_inst(pip_pkg::OP_ADD, 4, 1, 1, 0);
    send_inst(pip_pkg::OP_XOR, 5, 2, 1, 0);
    send_inst(pip_pkg::OP_SUB, 6, 1, 2, 0);
    drain_pipeline();
  endtask

  task automatic mul_back_to_back();
    send_inst(pip_pkg::OP_LI, 1, 0, 0, 16'hbeef);
    send_inst(pip_pkg::OP_LI, 2, 0, 0, 16'hface);
    drain_pipeline();
    send_inst(pip_pkg::OP_MUL, 10, 1, 2, 0);
    send_inst(pip_pkg::OP_MUL, 11, 2, 2, 0);
    send_inst(pip_pkg::OP_MUL, 12, 1, 1, 0);
    send_inst(pip_pkg::OP_MUL, 14, 10, 11, 0);
    drain_pipeline();
  endtask

  task automatic credit_flow();
    int sent_start;
    int back_start;
    send_inst(pip_pkg::OP_LI, 2, 0, 0, 3);
    send_inst(pip_pkg::OP_LI, 1, 0, 0, 1);
    drain_pipeline();
    sent_start       = sent_total;
    back_start       = credits_back;
    peak_outstanding = 0;
    // Dependent multiplies stall issue, so the sender runs out of credits
    for (int i = 0; i < pip_pkg::IQ_DEPTH + 4; i++) begin
      send_inst(pip_pkg::OP_MUL, 1, 1, 2, 0);
    end
    drain_pipeline();
    check_count("peak outstanding", peak_outstanding, pip_pkg::IQ_DEPTH);
    check_count("credits returned", credits_back - back_start, sent_total - sent_start);
  endtask

  task automatic random_program();
    int retire_start;
    retire_start = retired_total;
    for (int i = 0; i < RANDOM_INSTS; i++) begin
      send_inst(pip_pkg::op_e'($urandom_range(0, 7)), $urandom_range(0, 15),
                $urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 16'hffff));
    end
    // All issued once every credit is back
    while (credits_back != sent_total) begin
      @(negedge clock);
    end
    // Last multiply finishes, then a full ROB retires one per cycle
    repeat (pip_pkg::MUL_STAGES + pip_pkg::ROB_DEPTH + 4) begin
      @(posedge clock);
    end
    #DRIVE_DELAY;
    check_count("retire count", retired_total - retire_start, RANDOM_INSTS);
  endtask

  always @(posedge clock) begin : retire_monitor
    pip_pkg::retire_t front;
    if (rst_n) begin
      if (credit_return) begin
        credits_back++;
      end
      if (retire_valid) begin
        if (expected_q.size() == 0) begin
          abort_run("A result retired with no instruction outstanding");
        end else begin
          front = expected_q.pop_front();
          check_retire("retire", retire, front);
          retired_total++;
        end
      end
      if (credits_back > sent_total) begin
        abort_run("More credits came back than instructions were sent");
      end
    end
  end

  initial begin : watchdog
    while (cycle_count <= RESET_CYCLES + CYCLES_PER_INST * (sent_total + 1)) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run stopped making progress after %0d cycles", cycle_count);
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < pip_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(32'h2193_92a7));
    reset_dut();
    idle_after_reset();
    alu_chain();
    mul_then_alu();
    mul_back_to_back();
    credit_flow();
    random_program();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
pip_pkg.sv
inst_queue.sv
issue_ctrl.sv
rob.sv
alu_unit.sv
mul_unit.sv
rfile.sv
pipeline.sv
tb_pipeline.sv

// File: Bender.yml
package:
  name: pipeline

sources:
  - pip_pkg.sv
  - inst_queue.sv
  - issue_ctrl.sv
  - rob.sv
  - alu_unit.sv
  - mul_unit.sv
  - rfile.sv
  - pipeline.sv
  - target: simulation
    files:
      - tb_pipeline.sv
